//--- source/lspTdistPkg.sv
`default_nettype none

package lspTdistPkg;

	localparam int AddrWidth = 11;
	localparam int LspOrder = 10;

	typedef logic signed [15:0] word16;
	typedef logic signed [31:0] word32;
	typedef logic [AddrWidth-1:0] scratchAddr;

	// Everything one lane needs for one element
	typedef struct packed
	{
		word16 buff;
		word16 rbuf;
		word16 wegt;
		word16 fgSum;
	} laneOperand;

	typedef struct packed
	{
		logic valid;
		word32 term;
	} laneResult;

	typedef struct packed
	{
		word16 hi;
		word16 lo;
	} scratchHalves;

	// Vector and weight words are split into halves, the result is one long
	typedef union packed
	{
		word32 long;
		scratchHalves halves;
	} scratchWord;

	typedef struct packed
	{
		logic en;
		scratchAddr addr;
		scratchWord data;
	} hostWrite;

endpackage

`default_nettype wire

//--- source/scratchMemory.sv
`timescale 1ns/1ps
`default_nettype none

module scratchMemory
	import lspTdistPkg::*;
(
	input wire logic clk,
	input wire hostWrite hostWr,
	input wire logic accWrite,
	input wire scratchAddr accAddr,
	input wire scratchWord accData,
	input wire scratchAddr readAddr,
	output scratchWord readData
);

	localparam int Depth = 2 ** AddrWidth;

	scratchWord mem [Depth];

	scratchAddr writeAddr;
	scratchWord writeData;
	logic writeEn;

	//////////////////////////////////////////////////////////////////////
	// Write arbitration
	//////////////////////////////////////////////////////////////////////

	// Accumulator result beats the host, host word is lost
	always_comb
	begin
		writeEn = accWrite || hostWr.en;
		if (accWrite)
		begin
			writeAddr = accAddr;
			writeData = accData;
		end
		else
		begin
			writeAddr = hostWr.addr;
			writeData = hostWr.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// RAM array
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
	end

	// Registered read, data one clock after address
	always_ff @(posedge clk)
	begin
		readData <= mem[readAddr];
	end

endmodule

`default_nettype wire

//--- source/operandFetch.sv
`timescale 1ns/1ps
`default_nettype none

module operandFetch
	import lspTdistPkg::*;
#(
	parameter int NumLanes = 2
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire scratchAddr vectorBase,
	input wire scratchAddr weightBase,
	input wire scratchWord readData,
	input wire logic finish,
	output scratchAddr readAddr,
	output logic busy,
	output laneOperand laneIn [NumLanes],
	output logic [NumLanes-1:0] laneValid
);

	localparam int ElemWidth = $clog2(LspOrder);
	localparam int LaneWidth = (NumLanes > 1) ? $clog2(NumLanes) : 1;

	localparam logic [1:0] StIdle = 2'd0;
	localparam logic [1:0] StVector = 2'd1;
	localparam logic [1:0] StWeight = 2'd2;
	localparam logic [1:0] StDrain = 2'd3;

	logic [1:0] state;
	logic [ElemWidth-1:0] element;
	logic [LaneWidth-1:0] lanePtr;
	scratchAddr vectorBaseReg;
	scratchAddr weightBaseReg;
	logic vectorPending;
	logic weightPending;
	scratchWord vectorHold;
	laneOperand operand;

	assign busy = (state != StIdle);

	//////////////////////////////////////////////////////////////////////
	// Read sequencing, two reads per element
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= StIdle;
			element <= '0;
		end
		else
		begin
			case (state)
				StIdle:
				begin
					if (start)
					begin
						state <= StVector;
						element <= '0;
					end
				end
				StVector:
					state <= StWeight;
				StWeight:
				begin
					if (element == ElemWidth'(LspOrder - 1))
						state <= StDrain;
					else
					begin
						state <= StVector;
						element <= element + 1'b1;
					end
				end
				default:
				begin
					// Hold busy until the sum is written
					if (finish)
						state <= StIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start && !busy)
		begin
			vectorBaseReg <= vectorBase;
			weightBaseReg <= weightBase;
		end
	end

	always_comb
	begin
		case (state)
			StVector: readAddr = vectorBaseReg + scratchAddr'(element);
			StWeight: readAddr = weightBaseReg + scratchAddr'(element);
			default: readAddr = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Operand assembly and lane dispatch
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vectorPending <= 1'b0;
			weightPending <= 1'b0;
			lanePtr <= '0;
		end
		else
		begin
			vectorPending <= (state == StVector);
			weightPending <= (state == StWeight);
			if (start && !busy)
				lanePtr <= '0;
			else if (weightPending)
				lanePtr <= (lanePtr == LaneWidth'(NumLanes - 1)) ? '0 : lanePtr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (vectorPending)
			vectorHold <= readData;
	end

	// Weight word is still on the read port while the lane is strobed
	always_comb
	begin
		operand.buff = vectorHold.halves.hi;
		operand.rbuf = vectorHold.halves.lo;
		operand.wegt = readData.halves.hi;
		operand.fgSum = readData.halves.lo;
	end

	always_comb
	begin
		for (int i = 0; i < NumLanes; i++)
		begin
			laneIn[i] = operand;
			laneValid[i] = weightPending && (lanePtr == LaneWidth'(i));
		end
	end

endmodule

`default_nettype wire

//--- source/tdistLane.sv
`timescale 1ns/1ps
`default_nettype none

module tdistLane
	import lspTdistPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire laneOperand operand,
	input wire logic valid,
	output laneResult result
);

	//////////////////////////////////////////////////////////////////////
	// Saturating basic operators
	//////////////////////////////////////////////////////////////////////

	function automatic word16 saturate16(input logic signed [33:0] value);
		if (value > 34'sd32767)
			return 16'sh7fff;
		else if (value < -34'sd32768)
			return 16'sh8000;
		else
			return word16'(value);
	endfunction

	function automatic word16 subSat(input word16 a, input word16 b);
		logic signed [33:0] diff;
		diff = 34'(a) - 34'(b);
		return saturate16(diff);
	endfunction

	// Q15 product
	function automatic word16 multQ15(input word16 a, input word16 b);
		logic signed [33:0] product;
		product = 34'(a) * 34'(b);
		return saturate16(product >>> 15);
	endfunction

	// Doubled product, only 0x8000 times 0x8000 can overflow
	function automatic word32 lMult(input word16 a, input word16 b);
		logic signed [33:0] product;
		product = (34'(a) * 34'(b)) <<< 1;
		if (product > 34'sd2147483647)
			return 32'sh7fffffff;
		else
			return word32'(product);
	endfunction

	word16 eReg;
	word16 wegtReg;
	word16 eSquare;
	logic stage1Valid;
	logic termValid;
	word32 termReg;

	assign eSquare = multQ15(eReg, eReg);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stage1Valid <= 1'b0;
			termValid <= 1'b0;
		end
		else
		begin
			stage1Valid <= valid;
			termValid <= stage1Valid;
		end
	end

	// Stage 1 weighted difference, stage 2 weighted square
	always_ff @(posedge clk)
	begin
		if (valid)
		begin
			eReg <= multQ15(subSat(operand.buff, operand.rbuf), operand.fgSum);
			wegtReg <= operand.wegt;
		end
		if (stage1Valid)
			termReg <= lMult(wegtReg, eSquare);
	end

	assign result = '{valid: termValid, term: termReg};

endmodule

`default_nettype wire

//--- source/tdistAccumulate.sv
`timescale 1ns/1ps
`default_nettype none

module tdistAccumulate
	import lspTdistPkg::*;
#(
	parameter int NumLanes = 2
)
(
	input wire logic clk,
	input wire logic reset,
	input wire laneResult results [NumLanes],
	input wire scratchAddr resultAddr,
	input wire logic start,
	output logic accWrite,
	output scratchAddr accAddr,
	output scratchWord accData,
	output logic done
);

	localparam int CountWidth = $clog2(LspOrder + 1);

	function automatic word32 lAdd(input word32 a, input word32 b);
		logic signed [32:0] total;
		total = 33'(a) + 33'(b);
		if (total > 33'sd2147483647)
			return 32'sh7fffffff;
		else if (total < -33'sd2147483648)
			return 32'sh80000000;
		else
			return word32'(total);
	endfunction

	logic running;
	logic [CountWidth-1:0] termCount;
	word32 sum;
	logic termValid;
	word32 term;

	// Lanes never present a term in the same cycle
	always_comb
	begin
		termValid = 1'b0;
		term = '0;
		for (int i = 0; i < NumLanes; i++)
		begin
			if (results[i].valid)
			begin
				termValid = 1'b1;
				term = results[i].term;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			termCount <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (done)
				running <= 1'b0;
			else if (!running && start)
			begin
				running <= 1'b1;
				termCount <= '0;
			end
			else if (running && termValid)
			begin
				termCount <= termCount + 1'b1;
				if (termCount == CountWidth'(LspOrder - 1))
					done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!running && start)
		begin
			sum <= '0;
			accAddr <= resultAddr;
		end
		else if (running && termValid)
			sum <= lAdd(sum, term);
	end

	// Result goes out in the done cycle
	assign accWrite = done;

	always_comb
	begin
		accData.long = sum;
	end

endmodule

`default_nettype wire

//--- source/lspTdist.sv
`timescale 1ns/1ps
`default_nettype none

module lspTdist
	import lspTdistPkg::*;
#(
	parameter int NumLanes = 2
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire scratchAddr vectorBase,
	input wire scratchAddr weightBase,
	input wire scratchAddr resultAddr,
	input wire scratchAddr hostReadAddr,
	input wire hostWrite hostWr,
	output scratchWord hostReadData,
	output logic busy,
	output logic done
);

	scratchAddr fetchAddr;
	scratchAddr readAddr;
	scratchWord scratchRead;
	logic accWrite;
	scratchAddr accAddr;
	scratchWord accData;
	laneOperand laneIn [NumLanes];
	logic [NumLanes-1:0] laneValid;
	laneResult laneOut [NumLanes];

	// Host owns the read port whenever no run is active
	assign readAddr = busy ? fetchAddr : hostReadAddr;
	assign hostReadData = scratchRead;

	scratchMemory u_scratchMemory (
		.clk(clk),
		.hostWr(hostWr),
		.accWrite(accWrite),
		.accAddr(accAddr),
		.accData(accData),
		.readAddr(readAddr),
		.readData(scratchRead)
	);

	operandFetch #(
		.NumLanes(NumLanes)
	) u_operandFetch (
		.clk(clk),
		.reset(reset),
		.start(start),
		.vectorBase(vectorBase),
		.weightBase(weightBase),
		.readData(scratchRead),
		.finish(done),
		.readAddr(fetchAddr),
		.busy(busy),
		.laneIn(laneIn),
		.laneValid(laneValid)
	);

	//////////////////////////////////////////////////////////////////////
	// Distance lanes
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NumLanes; i++)
	begin : laneGen
		tdistLane u_tdistLane (
			.clk(clk),
			.reset(reset),
			.operand(laneIn[i]),
			.valid(laneValid[i]),
			.result(laneOut[i])
		);
	end

	tdistAccumulate #(
		.NumLanes(NumLanes)
	) u_tdistAccumulate (
		.clk(clk),
		.reset(reset),
		.results(laneOut),
		.resultAddr(resultAddr),
		.start(start),
		.accWrite(accWrite),
		.accAddr(accAddr),
		.accData(accData),
		.done(done)
	);

endmodule

`default_nettype wire

//--- bench/lspTdist_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lspTdistChecker
(
	input wire logic clk,
	input wire logic reset,
	input wire logic busy,
	input wire logic done
);

	// Done is a single cycle strobe
	donePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// A run is always active when done fires
	doneInRun: assert property (@(posedge clk) disable iff (reset) done |-> busy)
		else $error("done seen while busy was low");

	// Fetch returns to idle right after done
	busyDrops: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
		else $error("busy still high in the cycle after done");

endmodule

bind lspTdist lspTdistChecker u_lspTdistChecker (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.done(done)
);

`default_nettype wire

//--- bench/lspTdistBench.sv
`timescale 1ns/1ps
`default_nettype none

module lspTdistBench
	import lspTdistPkg::*;
();

	localparam int ClockPeriod = 10;
	localparam int NumRuns = 24;
	localparam int RunCycles = 200;

	logic clk;
	logic reset;
	logic start;
	scratchAddr vectorBase;
	scratchAddr weightBase;
	scratchAddr resultAddr;
	scratchAddr hostReadAddr;
	hostWrite hostWr;
	scratchWord hostReadData;
	logic busy;
	logic done;
	int doneCount;

	word16 bufVal [LspOrder];
	word16 rbufVal [LspOrder];
	word16 wegtVal [LspOrder];
	word16 fgSumVal [LspOrder];

	lspTdist #(
		.NumLanes(2)
	) u_lspTdist (
		.clk(clk),
		.reset(reset),
		.start(start),
		.vectorBase(vectorBase),
		.weightBase(weightBase),
		.resultAddr(resultAddr),
		.hostReadAddr(hostReadAddr),
		.hostWr(hostWr),
		.hostReadData(hostReadData),
		.busy(busy),
		.done(done)
	);

	initial
		clk = 1'b0;
	always #(ClockPeriod / 2) clk = ~clk;

	always @(negedge clk)
	begin
		if (!reset && done)
			doneCount++;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model of the codec operators
	//////////////////////////////////////////////////////////////////////

	function automatic word16 clip16(input longint value);
		if (value > 32767)
			return 16'sh7fff;
		if (value < -32768)
			return 16'sh8000;
		return word16'(value);
	endfunction

	function automatic word16 subModel(input word16 a, input word16 b);
		return clip16(longint'(a) - longint'(b));
	endfunction

	function automatic word16 multModel(input word16 a, input word16 b);
		return clip16((longint'(a) * longint'(b)) >>> 15);
	endfunction

	// Only -1 times -1 overflows the doubled product
	function automatic word32 lMultModel(input word16 a, input word16 b);
		if (a == -16'sd32768 && b == -16'sd32768)
			return 32'sh7fffffff;
		return word32'(longint'(a) * longint'(b) * 2);
	endfunction

	function automatic word32 lAddModel(input word32 a, input word32 b);
		longint total;
		total = longint'(a) + longint'(b);
		if (total > 64'sd2147483647)
			return 32'sh7fffffff;
		if (total < -64'sd2147483648)
			return 32'sh80000000;
		return word32'(total);
	endfunction

	function automatic word32 expectedSum();
		word32 total;
		word16 e;
		total = '0;
		for (int j = 0; j < LspOrder; j++)
		begin
			e = multModel(subModel(bufVal[j], rbufVal[j]), fgSumVal[j]);
			total = lAddModel(total, lMultModel(wegtVal[j], multModel(e, e)));
		end
		return total;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Host access and compare helpers
	//////////////////////////////////////////////////////////////////////

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkLong(input string name, input word32 expected, input word32 actual);
		if (expected !== actual)
			abortRun($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic checkWord(input string name, input scratchWord expected,
		input scratchWord actual);
		if (expected !== actual)
			abortRun($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
	endtask

	// All host tasks start and end on a falling edge
	task automatic writeScratch(input scratchAddr addr, input scratchWord data);
		hostWr = '{en: 1'b1, addr: addr, data: data};
		@(negedge clk);
		hostWr.en = 1'b0;
	endtask

	task automatic readScratch(input scratchAddr addr, output scratchWord data);
		hostReadAddr = addr;
		@(negedge clk);
		data = hostReadData;
	endtask

	task automatic randomizeVectors();
		for (int j = 0; j < LspOrder; j++)
		begin
			bufVal[j] = word16'($urandom());
			rbufVal[j] = word16'($urandom());
			wegtVal[j] = word16'($urandom());
			fgSumVal[j] = word16'($urandom());
		end
	endtask

	task automatic loadVectors(input scratchAddr vBase, input scratchAddr wBase);
		scratchWord word;
		for (int j = 0; j < LspOrder; j++)
		begin
			word.halves.hi = bufVal[j];
			word.halves.lo = rbufVal[j];
			writeScratch(vBase + scratchAddr'(j), word);
			word.halves.hi = wegtVal[j];
			word.halves.lo = fgSumVal[j];
			writeScratch(wBase + scratchAddr'(j), word);
		end
	endtask

	task automatic verifyVectors(input string name, input scratchAddr vBase,
		input scratchAddr wBase);
		scratchWord expected;
		scratchWord actual;
		for (int j = 0; j < LspOrder; j++)
		begin
			expected.halves.hi = bufVal[j];
			expected.halves.lo = rbufVal[j];
			readScratch(vBase + scratchAddr'(j), actual);
			checkWord($sformatf("%s vector %0d", name, j), expected, actual);
			expected.halves.hi = wegtVal[j];
			expected.halves.lo = fgSumVal[j];
			readScratch(wBase + scratchAddr'(j), actual);
			checkWord($sformatf("%s weight %0d", name, j), expected, actual);
		end
	endtask

	task automatic startPulse(input scratchAddr vBase, input scratchAddr wBase,
		input scratchAddr rAddr);
		vectorBase = vBase;
		weightBase = wBase;
		resultAddr = rAddr;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// Extra edge lets the result write land before readback
	task automatic waitDone();
		while (!done)
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic runRun(input scratchAddr vBase, input scratchAddr wBase,
		input scratchAddr rAddr);
		startPulse(vBase, wBase, rAddr);
		if (!busy)
			abortRun("busy did not rise in the cycle after start");
		waitDone();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic testRoundTrip();
		scratchWord expected;
		scratchWord actual;
		expected.halves.hi = 16'sh1234;
		expected.halves.lo = -16'sd2;
		writeScratch(11'h005, expected);
		readScratch(11'h005, actual);
		checkWord("roundTrip halves", expected, actual);
		checkLong("roundTrip halves as long", 32'sh1234fffe, actual.long);
		expected.long = 32'sh80000001;
		writeScratch(11'h7ff, expected);
		readScratch(11'h7ff, actual);
		checkWord("roundTrip long", expected, actual);
		checkLong("roundTrip long value", 32'sh80000001, actual.long);
	endtask

	task automatic testZeroDistance();
		scratchWord actual;
		randomizeVectors();
		for (int j = 0; j < LspOrder; j++)
			rbufVal[j] = bufVal[j];
		loadVectors(11'd100, 11'd200);
		runRun(11'd100, 11'd200, 11'd300);
		readScratch(11'd300, actual);
		checkLong("zeroDistance", 32'sd0, actual.long);
	endtask

	// Half scale inputs give 0x4000000 per term and odd elements get half weight
	task automatic testKnownVector();
		scratchWord actual;
		for (int j = 0; j < LspOrder; j++)
		begin
			bufVal[j] = (j % 3 == 0) ? 16'sd0 : 16'sd16384;
			rbufVal[j] = (j % 3 == 0) ? 16'sd16384 : 16'sd0;
			fgSumVal[j] = 16'sd16384;
			wegtVal[j] = (j % 2 == 1) ? 16'sd8192 : 16'sd16384;
		end
		loadVectors(11'd400, 11'd420);
		runRun(11'd400, 11'd420, 11'd440);
		readScratch(11'd440, actual);
		checkLong("knownVector", 32'sh1e000000, actual.long);
	endtask

	task automatic testSaturation();
		scratchWord actual;
		for (int j = 0; j < LspOrder; j++)
		begin
			bufVal[j] = 16'sh7fff;
			rbufVal[j] = 16'sh8000;
			fgSumVal[j] = 16'sh7fff;
			wegtVal[j] = 16'sh7fff;
		end
		loadVectors(11'd500, 11'd520);
		runRun(11'd500, 11'd520, 11'd540);
		readScratch(11'd540, actual);
		checkLong("saturation", 32'sh7fffffff, actual.long);
	endtask

	// Result sits between the two input regions
	task automatic testRandomRuns();
		scratchAddr vBase;
		scratchAddr wBase;
		scratchAddr rAddr;
		scratchWord actual;
		for (int i = 0; i < 20; i++)
		begin
			randomizeVectors();
			vBase = scratchAddr'($urandom_range(0, 1900));
			rAddr = vBase + scratchAddr'(LspOrder);
			wBase = rAddr + 1'b1 + scratchAddr'($urandom_range(0, 40));
			loadVectors(vBase, wBase);
			runRun(vBase, wBase, rAddr);
			readScratch(rAddr, actual);
			checkLong($sformatf("randomRun %0d", i), expectedSum(), actual.long);
			verifyVectors($sformatf("randomRun %0d", i), vBase, wBase);
		end
	endtask

	task automatic testStartWhileBusy();
		scratchWord marker;
		scratchWord actual;
		word32 expected;
		randomizeVectors();
		loadVectors(11'd1000, 11'd1020);
		marker.long = 32'sh5a5a1234;
		writeScratch(11'd1040, marker);
		randomizeVectors();
		loadVectors(11'd1100, 11'd1120);
		expected = expectedSum();
		doneCount = 0;
		startPulse(11'd1100, 11'd1120, 11'd1140);
		repeat (3) @(negedge clk);
		startPulse(11'd1000, 11'd1020, 11'd1040);
		waitDone();
		repeat (30) @(negedge clk);
		if (doneCount != 1)
			abortRun($sformatf("startWhileBusy: %0d done pulses instead of one", doneCount));
		readScratch(11'd1140, actual);
		checkLong("startWhileBusy result", expected, actual.long);
		readScratch(11'd1040, actual);
		checkWord("startWhileBusy ignored result", marker, actual);
	endtask

	// Reset margin on top of the per run budget
	initial
	begin
		#(ClockPeriod * (RunCycles * NumRuns + 20));
		abortRun("Timeout: done never arrived within the allowed cycles");
	end

	initial
	begin
		void'($urandom(65001));
		reset = 1'b1;
		start = 1'b0;
		vectorBase = '0;
		weightBase = '0;
		resultAddr = '0;
		hostReadAddr = '0;
		hostWr = '0;
		doneCount = 0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		testRoundTrip();
		testZeroDistance();
		testKnownVector();
		testSaturation();
		testRandomRuns();
		testStartWhileBusy();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- lspTdist.f
source/lspTdistPkg.sv
source/scratchMemory.sv
source/operandFetch.sv
source/tdistLane.sv
source/tdistAccumulate.sv
source/lspTdist.sv
bench/lspTdist_checker.sv
bench/lspTdistBench.sv

//--- Bender.yml
package:
  name: lspTdist

sources:
  - source/lspTdistPkg.sv
  - source/scratchMemory.sv
  - source/operandFetch.sv
  - source/tdistLane.sv
  - source/tdistAccumulate.sv
  - source/lspTdist.sv
  - target: simulation
    files:
      - bench/lspTdist_checker.sv
      - bench/lspTdistBench.sv
